// File: tb.f
+incdir+include
rtl/imx_ctrl_pkg.sv
rtl/axi_lite_reg_port.sv
rtl/imx_reg_bank.sv
rtl/imx_trigger_gen.sv
rtl/imx_camera_control.sv
verification/tb_imx_camera_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the camera controller testbench with Verilator
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module tb_imx_camera_control \
  -Mdir build \
  -o tb_sim

./build/tb_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi

echo "simulation finished without failure"

// File: verification/tb_imx_camera_control.sv
// Testbench for the IMX camera controller top level.
// Drives AXI-Lite traffic on the falling clock edge, checks register values
// with immediate assertions and bus and pulse timing with concurrent ones,
// then prints one closing error count line.

`timescale 1ns/1ps
`default_nettype none

`include "imx_ctrl_config.svh"

module tb_imx_camera_control import imx_ctrl_pkg::*; ();

  // Full sequence needs roughly 500 cycles
  localparam int MAX_CYCLES = 5000;
  localparam int TAP_SLOTS  = `IMX_CAMERA_COUNT * `IMX_LANE_COUNT;
  localparam axi_data_t CTRL_LEVEL_MASK = (32'h1 << `IMX_CTRL_BIT_CLEAR) |
                                          (32'h1 << `IMX_CTRL_BIT_TRIG_EN) |
                                          (32'h7 << `IMX_CTRL_BIT_MASTER0);

  logic       i_axi_clk;
  logic       i_axi_rst_n;
  logic       i_awvalid;
  axi_addr_t  i_awaddr;
  logic       i_wvalid;
  axi_data_t  i_wdata;
  logic       i_bready;
  logic       i_arvalid;
  axi_addr_t  i_araddr;
  logic       i_rready;
  logic       o_awready;
  logic       o_wready;
  logic       o_bvalid;
  axi_resp_t  o_bresp;
  logic       o_arready;
  logic       o_rvalid;
  axi_resp_t  o_rresp;
  axi_data_t  o_rdata;
  cam_vec_t   o_imx_trigger;
  logic       o_cam_xclear_n;
  cam_vec_t   o_master_mode;
  logic       o_tap_delay_rst;
  logic       o_serdes_clk_rst_stb;
  logic       o_serdes_io_rst;
  tap_bus_t   o_cam_tap_data;

  int         value_errors = 0;
  int         protocol_errors = 0;
  int         cycle_count = 0;
  cam_vec_t   resp_trigger;
  tap_value_t tap_exp [TAP_SLOTS];
  axi_data_t  exp_width;
  axi_data_t  exp_period;
  axi_data_t  exp_ctrl;
  logic       ctrl_wr;

  imx_camera_control u_imx_camera_control (
    .i_axi_clk            (i_axi_clk),
    .i_axi_rst_n          (i_axi_rst_n),
    .i_awvalid            (i_awvalid),
    .i_awaddr             (i_awaddr),
    .o_awready            (o_awready),
    .i_wvalid             (i_wvalid),
    .i_wdata              (i_wdata),
    .o_wready             (o_wready),
    .o_bvalid             (o_bvalid),
    .i_bready             (i_bready),
    .o_bresp              (o_bresp),
    .i_arvalid            (i_arvalid),
    .i_araddr             (i_araddr),
    .o_arready            (o_arready),
    .o_rvalid             (o_rvalid),
    .i_rready             (i_rready),
    .o_rresp              (o_rresp),
    .o_rdata              (o_rdata),
    .o_imx_trigger        (o_imx_trigger),
    .o_cam_xclear_n       (o_cam_xclear_n),
    .o_master_mode        (o_master_mode),
    .o_tap_delay_rst      (o_tap_delay_rst),
    .o_serdes_clk_rst_stb (o_serdes_clk_rst_stb),
    .o_serdes_io_rst      (o_serdes_io_rst),
    .o_cam_tap_data       (o_cam_tap_data)
  );

  initial i_axi_clk = 1'b0;
  always #2 i_axi_clk = ~i_axi_clk;

  always @(posedge i_axi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic flag_mismatch(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    value_errors++;
    $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
  endtask

  task automatic flag_protocol(input string what);
    protocol_errors++;
    $display("error at cycle %0d: %s", cycle_count, what);
  endtask

  // Handshake on a control word write, seen in the accepting cycle
  assign ctrl_wr = o_awready &&
                   (i_awaddr[`IMX_ADDR_WIDTH-1:2] == reg_index_t'(`IMX_REG_CONTROL));

  a_bvalid_hold: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    o_bvalid && !i_bready |=> o_bvalid)
    else flag_protocol("write response dropped before bready");
  a_aw_blocked: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    o_bvalid |-> !o_awready && !o_wready)
    else flag_protocol("new write accepted while a response was pending");
  a_wr_handshake: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    $rose(o_bvalid) |-> $past(o_awready && o_wready))
    else flag_protocol("write response without a joint address and data handshake");
  a_rd_handshake: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    $rose(o_rvalid) |-> $past(o_arready, 2))
    else flag_protocol("read data without an address handshake two cycles earlier");

  a_tap_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    ctrl_wr && i_wdata[`IMX_CTRL_BIT_TAP_RST] |=> o_tap_delay_rst ##1 !o_tap_delay_rst)
    else flag_protocol("tap delay reset was not a single pulse after the write");
  a_tap_rst_src: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    o_tap_delay_rst |-> $past(ctrl_wr && i_wdata[`IMX_CTRL_BIT_TAP_RST]))
    else flag_protocol("tap delay reset pulsed without a control write");
  a_clk_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    ctrl_wr && i_wdata[`IMX_CTRL_BIT_CLK_RST] |=> o_serdes_clk_rst_stb ##1 !o_serdes_clk_rst_stb)
    else flag_protocol("serdes clock reset was not a single pulse after the write");
  a_clk_rst_src: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    o_serdes_clk_rst_stb |-> $past(ctrl_wr && i_wdata[`IMX_CTRL_BIT_CLK_RST]))
    else flag_protocol("serdes clock reset pulsed without a control write");
  a_io_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    ctrl_wr && i_wdata[`IMX_CTRL_BIT_CAM_RST] |=> o_serdes_io_rst ##1 !o_serdes_io_rst)
    else flag_protocol("serdes io reset was not a single pulse after the write");
  a_io_rst_src: assert property (@(posedge i_axi_clk) disable iff (!i_axi_rst_n)
    o_serdes_io_rst |-> $past(ctrl_wr && i_wdata[`IMX_CTRL_BIT_CAM_RST]))
    else flag_protocol("serdes io reset pulsed without a control write");

  // Word index of a tap slot, each camera reserves 16 words
  function automatic int tap_index(input int slot);
    return 16 + (slot / 8) * 16 + (slot % 8);
  endfunction

  function automatic tap_bus_t expected_taps();
    tap_bus_t bus;
    bus = '0;
    for (int s = 0; s < TAP_SLOTS; s++) begin
      bus[s*5 +: 5] = tap_exp[s];
    end
    return bus;
  endfunction

  task automatic write_word(input int index, input axi_data_t data, output axi_resp_t resp);
    int wait_cycles;
    @(negedge i_axi_clk);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = axi_addr_t'(index * 4);
    i_wdata   = data;
    i_bready  = 1'b1;
    wait_cycles = 0;
    do begin
      @(negedge i_axi_clk);
      wait_cycles++;
    end while (!o_bvalid && wait_cycles < 20);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    resp = o_bresp;
    resp_trigger = o_imx_trigger;
    assert (o_bvalid) else flag_protocol("write response did not arrive");
    assert (wait_cycles == 1) else flag_mismatch("write latency", wait_cycles, 1);
  endtask

  task automatic read_word(input int index, output axi_data_t data, output axi_resp_t resp);
    int wait_cycles;
    @(negedge i_axi_clk);
    i_arvalid = 1'b1;
    i_araddr  = axi_addr_t'(index * 4);
    i_rready  = 1'b1;
    @(negedge i_axi_clk);
    i_arvalid = 1'b0;
    wait_cycles = 1;
    while (!o_rvalid && wait_cycles < 20) begin
      @(negedge i_axi_clk);
      wait_cycles++;
    end
    data = o_rdata;
    resp = o_rresp;
    assert (o_rvalid) else flag_protocol("read data did not arrive");
    assert (wait_cycles == 2) else flag_mismatch("read latency", wait_cycles, 2);
  endtask

  task automatic expect_write_ok(input int index, input axi_data_t data, input string name);
    axi_resp_t resp;
    write_word(index, data, resp);
    assert (resp == RESP_OKAY) else flag_mismatch({"o_bresp ", name}, resp, RESP_OKAY);
  endtask

  task automatic expect_read(input int index, input axi_data_t exp, input string name);
    axi_data_t data;
    axi_resp_t resp;
    read_word(index, data, resp);
    assert (resp == RESP_OKAY) else flag_mismatch({"o_rresp ", name}, resp, RESP_OKAY);
    assert (data == exp) else flag_mismatch({"o_rdata ", name}, data, exp);
  endtask

  task automatic check_reset_values();
    assert (o_imx_trigger == '0) else flag_mismatch("o_imx_trigger", o_imx_trigger, 0);
    assert (o_cam_xclear_n) else flag_mismatch("o_cam_xclear_n", o_cam_xclear_n, 1);
    assert (o_master_mode == '0) else flag_mismatch("o_master_mode", o_master_mode, 0);
    assert (!o_awready && !o_bvalid && !o_arready && !o_rvalid)
      else flag_protocol("bus handshake outputs not idle after reset");
    assert (!o_tap_delay_rst && !o_serdes_clk_rst_stb && !o_serdes_io_rst)
      else flag_protocol("control pulse high after reset");
    expect_read(`IMX_REG_PULSE_WIDTH, 100, "pulse width");
    expect_read(`IMX_REG_PERIOD, 370000, "period");
    expect_read(`IMX_REG_CONTROL, 0, "control");
    expect_read(`IMX_REG_CAMERA_COUNT, 3, "camera count");
    expect_read(`IMX_REG_LANE_COUNT, 8, "lane count");
    expect_read(`IMX_REG_VERSION, 32'h1000_0000, "version");
    exp_width  = 100;
    exp_period = 370000;
    exp_ctrl   = '0;
  endtask

  task automatic check_tap_round_trip();
    axi_data_t val;
    int        start;
    int        slot;
    for (int s = 0; s < TAP_SLOTS; s++) begin
      val = $urandom();
      tap_exp[s] = val[4:0];
      expect_write_ok(tap_index(s), val, "tap write");
    end
    assert (o_cam_tap_data == expected_taps())
      else flag_mismatch("o_cam_tap_data", o_cam_tap_data, expected_taps());
    // Read back in a rotated order
    start = $urandom_range(0, TAP_SLOTS - 1);
    for (int k = 0; k < TAP_SLOTS; k++) begin
      slot = (start + k) % TAP_SLOTS;
      expect_read(tap_index(slot), axi_data_t'(tap_exp[slot]), "tap");
    end
    // Reserved lane 12 ignores the write
    slot = 16 + $urandom_range(0, 2) * 16 + 12;
    expect_write_ok(slot, $urandom(), "reserved tap write");
    expect_read(slot, 0, "reserved tap");
    assert (o_cam_tap_data == expected_taps())
      else flag_mismatch("o_cam_tap_data", o_cam_tap_data, expected_taps());
  endtask

  task automatic check_address_errors();
    int        idx;
    axi_data_t data;
    axi_resp_t resp;
    idx = $urandom_range(65, 127);
    write_word(idx, 32'hFFFF_FFFF, resp);
    assert (resp == RESP_SLVERR) else flag_mismatch("o_bresp out of range", resp, RESP_SLVERR);
    read_word(idx, data, resp);
    assert (resp == RESP_SLVERR) else flag_mismatch("o_rresp out of range", resp, RESP_SLVERR);
    expect_read(`IMX_REG_PULSE_WIDTH, exp_width, "pulse width");
    expect_read(`IMX_REG_PERIOD, exp_period, "period");
    expect_read(`IMX_REG_CONTROL, exp_ctrl, "control");
    expect_read(1, 0, "word 1");
    expect_read(7, 0, "word 7");
    expect_read(8, 0, "word 8");
    assert (o_cam_tap_data == expected_taps())
      else flag_mismatch("o_cam_tap_data", o_cam_tap_data, expected_taps());
  endtask

  task automatic check_control_write();
    cam_vec_t  mode;
    axi_data_t data;
    mode = cam_vec_t'($urandom_range(1, 7));
    data = '0;
    data[`IMX_CTRL_BIT_CLEAR]   = 1'b1;
    data[`IMX_CTRL_BIT_TAP_RST] = 1'b1;
    data[`IMX_CTRL_BIT_CLK_RST] = 1'b1;
    data[`IMX_CTRL_BIT_CAM_RST] = 1'b1;
    data[`IMX_CTRL_BIT_MASTER0 +: 3] = mode;
    expect_write_ok(`IMX_REG_CONTROL, data, "control write");
    exp_ctrl = data & CTRL_LEVEL_MASK;
    assert (o_master_mode == mode) else flag_mismatch("o_master_mode", o_master_mode, mode);
    assert (!o_cam_xclear_n) else flag_mismatch("o_cam_xclear_n", o_cam_xclear_n, 0);
    expect_read(`IMX_REG_CONTROL, exp_ctrl, "control");
    // Release clear and flip the master modes, no pulses this time
    data = '0;
    data[`IMX_CTRL_BIT_MASTER0 +: 3] = ~mode;
    expect_write_ok(`IMX_REG_CONTROL, data, "control write");
    exp_ctrl = data & CTRL_LEVEL_MASK;
    assert (o_master_mode == ~mode) else flag_mismatch("o_master_mode", o_master_mode, ~mode);
    assert (o_cam_xclear_n) else flag_mismatch("o_cam_xclear_n", o_cam_xclear_n, 1);
    expect_read(`IMX_REG_CONTROL, exp_ctrl, "control");
  endtask

  task automatic check_trigger_pattern();
    cam_vec_t  samples [40];
    int        high;
    axi_data_t data;
    exp_width  = 3;
    exp_period = 10;
    expect_write_ok(`IMX_REG_PULSE_WIDTH, exp_width, "pulse width write");
    expect_write_ok(`IMX_REG_PERIOD, exp_period, "period write");
    data = '0;
    data[`IMX_CTRL_BIT_TRIG_EN] = 1'b1;
    expect_write_ok(`IMX_REG_CONTROL, data, "trigger enable");
    exp_ctrl = data & CTRL_LEVEL_MASK;
    assert (resp_trigger == 3'b111) else flag_mismatch("o_imx_trigger", resp_trigger, 3'b111);
    for (int k = 0; k < 40; k++) begin
      @(negedge i_axi_clk);
      samples[k] = o_imx_trigger;
    end
    // Every window of one period holds exactly width high cycles per line
    for (int w = 0; w <= 30; w++) begin
      for (int b = 0; b < 3; b++) begin
        high = 0;
        for (int k = w; k < w + 10; k++) begin
          high += int'(samples[k][b]);
        end
        assert (high == 3) else flag_mismatch("o_imx_trigger high cycles", high, 3);
      end
    end
    expect_write_ok(`IMX_REG_CONTROL, 0, "trigger disable");
    exp_ctrl = '0;
    repeat (25) begin
      @(negedge i_axi_clk);
      assert (o_imx_trigger == '0) else flag_mismatch("o_imx_trigger", o_imx_trigger, 0);
    end
  endtask

  task automatic check_write_backpressure();
    int wait_cycles;
    @(negedge i_axi_clk);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = axi_addr_t'(`IMX_REG_PULSE_WIDTH * 4);
    i_wdata   = 7;
    i_bready  = 1'b0;
    @(negedge i_axi_clk);
    assert (o_bvalid) else flag_protocol("first held write got no response");
    // Second write waits behind the held response
    i_awaddr = axi_addr_t'(`IMX_REG_PERIOD * 4);
    i_wdata  = 55;
    expect_read(`IMX_REG_PULSE_WIDTH, 7, "pulse width");
    expect_read(`IMX_REG_PERIOD, exp_period, "period");
    assert (o_bvalid && !o_awready) else flag_protocol("held response released early");
    i_bready = 1'b1;
    wait_cycles = 0;
    do begin
      @(negedge i_axi_clk);
      wait_cycles++;
    end while (!o_bvalid && wait_cycles < 20);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    assert (o_bvalid) else flag_protocol("pending write was never accepted");
    assert (o_bresp == RESP_OKAY) else flag_mismatch("o_bresp", o_bresp, RESP_OKAY);
    exp_width  = 7;
    exp_period = 55;
    expect_read(`IMX_REG_PULSE_WIDTH, exp_width, "pulse width");
    expect_read(`IMX_REG_PERIOD, exp_period, "period");
  endtask

  initial begin
    void'($urandom(71));
    i_axi_rst_n = 1'b0;
    i_awvalid   = 1'b0;
    i_awaddr    = '0;
    i_wvalid    = 1'b0;
    i_wdata     = '0;
    i_bready    = 1'b0;
    i_arvalid   = 1'b0;
    i_araddr    = '0;
    i_rready    = 1'b0;
    repeat (2) @(negedge i_axi_clk);
    i_axi_rst_n = 1'b1;
    check_reset_values();
    check_tap_round_trip();
    check_address_errors();
    check_control_write();
    check_trigger_pattern();
    check_write_backpressure();
    repeat (4) @(negedge i_axi_clk);
    $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/imx_camera_control.sv
// Top level of the IMX camera controller.
// Inverts the active-low bus reset and connects the AXI-Lite front end,
// the register bank and the trigger generator.

`timescale 1ns/1ps
`default_nettype none

module imx_camera_control import imx_ctrl_pkg::*; (
  input  wire        i_axi_clk,
  input  wire        i_axi_rst_n,
  input  wire        i_awvalid,
  input  axi_addr_t  i_awaddr,
  output logic       o_awready,
  input  wire        i_wvalid,
  input  axi_data_t  i_wdata,
  output logic       o_wready,
  output logic       o_bvalid,
  input  wire        i_bready,
  output axi_resp_t  o_bresp,
  input  wire        i_arvalid,
  input  axi_addr_t  i_araddr,
  output logic       o_arready,
  output logic       o_rvalid,
  input  wire        i_rready,
  output axi_resp_t  o_rresp,
  output axi_data_t  o_rdata,
  output cam_vec_t   o_imx_trigger,
  output logic       o_cam_xclear_n,
  output cam_vec_t   o_master_mode,
  output logic       o_tap_delay_rst,
  output logic       o_serdes_clk_rst_stb,
  output logic       o_serdes_io_rst,
  output tap_bus_t   o_cam_tap_data
);

  logic        w_axi_rst;
  logic        w_wr_stb;
  reg_index_t  w_wr_index;
  axi_data_t   w_wr_data;
  logic        w_wr_err;
  reg_index_t  w_rd_index;
  axi_data_t   w_rd_data;
  logic        w_rd_err;
  logic        w_trigger_en;
  trig_count_t w_pulse_width;
  trig_count_t w_period;
  logic        w_cam_rst_stb;

  assign w_axi_rst       = ~i_axi_rst_n;
  assign o_serdes_io_rst = w_cam_rst_stb;

  axi_lite_reg_port u_reg_port (
    .i_axi_clk  (i_axi_clk),
    .i_axi_rst  (w_axi_rst),
    .i_awvalid  (i_awvalid),
    .i_awaddr   (i_awaddr),
    .o_awready  (o_awready),
    .i_wvalid   (i_wvalid),
    .i_wdata    (i_wdata),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_bresp    (o_bresp),
    .i_arvalid  (i_arvalid),
    .i_araddr   (i_araddr),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_rresp    (o_rresp),
    .o_rdata    (o_rdata),
    .o_wr_stb   (w_wr_stb),
    .o_wr_index (w_wr_index),
    .o_wr_data  (w_wr_data),
    .i_wr_err   (w_wr_err),
    .o_rd_index (w_rd_index),
    .i_rd_data  (w_rd_data),
    .i_rd_err   (w_rd_err)
  );

  imx_reg_bank u_reg_bank (
    .i_axi_clk            (i_axi_clk),
    .i_axi_rst            (w_axi_rst),
    .i_wr_stb             (w_wr_stb),
    .i_wr_index           (w_wr_index),
    .i_wr_data            (w_wr_data),
    .o_wr_err             (w_wr_err),
    .i_rd_index           (w_rd_index),
    .o_rd_data            (w_rd_data),
    .o_rd_err             (w_rd_err),
    .o_trigger_en         (w_trigger_en),
    .o_pulse_width        (w_pulse_width),
    .o_period             (w_period),
    .o_master_mode        (o_master_mode),
    .o_cam_xclear_n       (o_cam_xclear_n),
    .o_tap_delay_rst      (o_tap_delay_rst),
    .o_serdes_clk_rst_stb (o_serdes_clk_rst_stb),
    .o_cam_rst_stb        (w_cam_rst_stb),
    .o_cam_tap_data       (o_cam_tap_data)
  );

  imx_trigger_gen u_trigger_gen (
    .i_axi_clk     (i_axi_clk),
    .i_axi_rst     (w_axi_rst),
    .i_trigger_en  (w_trigger_en),
    .i_pulse_width (w_pulse_width),
    .i_period      (w_period),
    .i_cam_rst_stb (w_cam_rst_stb),
    .o_imx_trigger (o_imx_trigger)
  );

endmodule

`default_nettype wire

// File: rtl/imx_trigger_gen.sv
// Periodic trigger for the image sensors.
// One period counter shared by all cameras, each trigger line is high
// for the first pulse-width cycles of every period while enabled.

`timescale 1ns/1ps
`default_nettype none

module imx_trigger_gen import imx_ctrl_pkg::*; (
  input  wire         i_axi_clk,
  input  wire         i_axi_rst,
  input  wire         i_trigger_en,
  input  trig_count_t i_pulse_width,
  input  trig_count_t i_period,
  input  wire         i_cam_rst_stb,
  output cam_vec_t    o_imx_trigger
);

  trig_count_t r_count;
  trig_count_t w_last;
  logic        w_fire;

  // Zero period acts as a period of one
  assign w_last = (i_period == '0) ? '0 : i_period - trig_count_t'(1);

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst || !i_trigger_en || i_cam_rst_stb) begin
      r_count <= '0;
    end else if (r_count >= w_last) begin
      r_count <= '0;
    end else begin
      r_count <= r_count + trig_count_t'(1);
    end
  end

  // Counter idles at zero, so the pulse starts as soon as enable is seen
  assign w_fire        = i_trigger_en && (r_count < i_pulse_width);
  assign o_imx_trigger = {$bits(cam_vec_t){w_fire}};

  // A fresh enable starts a new period with the trigger high
  a_trigger_start: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    !i_trigger_en ##1 i_trigger_en |-> (o_imx_trigger == '1) || (i_pulse_width == '0));

endmodule

`default_nettype wire

// File: rtl/imx_reg_bank.sv
// Register bank of the IMX camera controller.
// Decodes word indices from the bus front end, holds control, trigger
// and tap-delay settings, serves the combinational read mux and issues
// the one-cycle control pulses after a control write.

`timescale 1ns/1ps
`default_nettype none

`include "imx_ctrl_config.svh"

module imx_reg_bank import imx_ctrl_pkg::*; (
  input  wire         i_axi_clk,
  input  wire         i_axi_rst,
  input  wire         i_wr_stb,
  input  reg_index_t  i_wr_index,
  input  axi_data_t   i_wr_data,
  output logic        o_wr_err,
  input  reg_index_t  i_rd_index,
  output axi_data_t   o_rd_data,
  output logic        o_rd_err,
  output logic        o_trigger_en,
  output trig_count_t o_pulse_width,
  output trig_count_t o_period,
  output cam_vec_t    o_master_mode,
  output logic        o_cam_xclear_n,
  output logic        o_tap_delay_rst,
  output logic        o_serdes_clk_rst_stb,
  output logic        o_cam_rst_stb,
  output tap_bus_t    o_cam_tap_data
);

  localparam int TAP_REGS = `IMX_CAMERA_COUNT * `IMX_LANE_COUNT;

  localparam reg_index_t IDX_CONTROL   = reg_index_t'(`IMX_REG_CONTROL);
  localparam reg_index_t IDX_WIDTH     = reg_index_t'(`IMX_REG_PULSE_WIDTH);
  localparam reg_index_t IDX_PERIOD    = reg_index_t'(`IMX_REG_PERIOD);
  localparam reg_index_t IDX_CAM_COUNT = reg_index_t'(`IMX_REG_CAMERA_COUNT);
  localparam reg_index_t IDX_LANES     = reg_index_t'(`IMX_REG_LANE_COUNT);
  localparam reg_index_t IDX_TAP_START = reg_index_t'(`IMX_REG_TAP_START);
  localparam reg_index_t IDX_VERSION   = reg_index_t'(`IMX_REG_VERSION);

  logic        r_trigger_en;
  cam_vec_t    r_master_mode;
  logic        r_cam_xclear_n;
  trig_count_t r_pulse_width;
  trig_count_t r_period;
  tap_value_t  r_tap [TAP_REGS];
  logic        r_tap_delay_rst;
  logic        r_serdes_clk_rst_stb;
  logic        r_cam_rst_stb;
  logic        w_wr_en;

  // Tap word belongs to an active lane, upper lanes of each camera are reserved
  function automatic logic tap_hit(reg_index_t idx);
    reg_index_t off;
    off = idx - IDX_TAP_START;
    return (idx >= IDX_TAP_START) && (idx < IDX_VERSION) &&
           ((int'(off) % `IMX_MAX_LANE_COUNT) < `IMX_LANE_COUNT);
  endfunction

  // Flat slot of a tap word, camera major
  function automatic int tap_slot(reg_index_t idx);
    int off;
    off = int'(idx - IDX_TAP_START);
    return (off / `IMX_MAX_LANE_COUNT) * `IMX_LANE_COUNT + (off % `IMX_MAX_LANE_COUNT);
  endfunction

  assign o_wr_err = (i_wr_index > IDX_VERSION);
  assign o_rd_err = (i_rd_index > IDX_VERSION);
  assign w_wr_en  = i_wr_stb && !o_wr_err;

  always_ff @(posedge i_axi_clk) begin
    r_tap_delay_rst      <= 1'b0;
    r_serdes_clk_rst_stb <= 1'b0;
    r_cam_rst_stb        <= 1'b0;
    if (i_axi_rst) begin
      r_trigger_en   <= 1'b0;
      r_master_mode  <= '0;
      r_cam_xclear_n <= 1'b1;
      r_pulse_width  <= trig_count_t'(`IMX_DEFAULT_PULSE_WIDTH);
      r_period       <= trig_count_t'(`IMX_DEFAULT_PERIOD);
      for (int k = 0; k < TAP_REGS; k++) begin
        r_tap[k] <= '0;
      end
    end else if (w_wr_en) begin
      case (i_wr_index)
        IDX_CONTROL: begin
          r_cam_xclear_n       <= ~i_wr_data[`IMX_CTRL_BIT_CLEAR];
          r_trigger_en         <= i_wr_data[`IMX_CTRL_BIT_TRIG_EN];
          r_master_mode        <= i_wr_data[`IMX_CTRL_BIT_MASTER0 +: `IMX_CAMERA_COUNT];
          r_tap_delay_rst      <= i_wr_data[`IMX_CTRL_BIT_TAP_RST];
          r_serdes_clk_rst_stb <= i_wr_data[`IMX_CTRL_BIT_CLK_RST];
          r_cam_rst_stb        <= i_wr_data[`IMX_CTRL_BIT_CAM_RST];
        end
        IDX_WIDTH:  r_pulse_width <= i_wr_data;
        IDX_PERIOD: r_period      <= i_wr_data;
        default: begin
          if (tap_hit(i_wr_index)) begin
            r_tap[tap_slot(i_wr_index)] <= i_wr_data[`IMX_TAP_WIDTH-1:0];
          end
        end
      endcase
    end
  end

  // Read mux, unused words in range read as zero
  always_comb begin
    o_rd_data = '0;
    case (i_rd_index)
      IDX_CONTROL: begin
        o_rd_data[`IMX_CTRL_BIT_CLEAR]   = ~r_cam_xclear_n;
        o_rd_data[`IMX_CTRL_BIT_TRIG_EN] = r_trigger_en;
        o_rd_data[`IMX_CTRL_BIT_MASTER0 +: `IMX_CAMERA_COUNT] = r_master_mode;
      end
      IDX_WIDTH:     o_rd_data = r_pulse_width;
      IDX_PERIOD:    o_rd_data = r_period;
      IDX_CAM_COUNT: o_rd_data = axi_data_t'(`IMX_CAMERA_COUNT);
      IDX_LANES:     o_rd_data = axi_data_t'(`IMX_LANE_COUNT);
      IDX_VERSION:   o_rd_data = `IMX_VERSION_WORD;
      default: begin
        if (tap_hit(i_rd_index)) begin
          o_rd_data = axi_data_t'(r_tap[tap_slot(i_rd_index)]);
        end
      end
    endcase
  end

  // Camera 0 lane 0 sits in the lowest bits
  for (genvar g = 0; g < TAP_REGS; g++) begin : g_tap_out
    assign o_cam_tap_data[g*`IMX_TAP_WIDTH +: `IMX_TAP_WIDTH] = r_tap[g];
  end

  assign o_trigger_en         = r_trigger_en;
  assign o_pulse_width        = r_pulse_width;
  assign o_period             = r_period;
  assign o_master_mode        = r_master_mode;
  assign o_cam_xclear_n       = r_cam_xclear_n;
  assign o_tap_delay_rst      = r_tap_delay_rst;
  assign o_serdes_clk_rst_stb = r_serdes_clk_rst_stb;
  assign o_cam_rst_stb        = r_cam_rst_stb;

  // Writes are spaced by the response phase, so pulses never merge
  a_tap_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    o_tap_delay_rst |=> !o_tap_delay_rst);
  a_clk_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    o_serdes_clk_rst_stb |=> !o_serdes_clk_rst_stb);
  a_cam_rst_pulse: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    o_cam_rst_stb |=> !o_cam_rst_stb);

endmodule

`default_nettype wire

// File: rtl/axi_lite_reg_port.sv
// AXI-Lite slave front end for the camera register bank.
// Accepts address and data together, presents a one-cycle write strobe
// and a registered read index, and holds each response until taken.

`timescale 1ns/1ps
`default_nettype none

`include "imx_ctrl_config.svh"

module axi_lite_reg_port import imx_ctrl_pkg::*; (
  input  wire        i_axi_clk,
  input  wire        i_axi_rst,
  input  wire        i_awvalid,
  input  axi_addr_t  i_awaddr,
  output logic       o_awready,
  input  wire        i_wvalid,
  input  axi_data_t  i_wdata,
  output logic       o_wready,
  output logic       o_bvalid,
  input  wire        i_bready,
  output axi_resp_t  o_bresp,
  input  wire        i_arvalid,
  input  axi_addr_t  i_araddr,
  output logic       o_arready,
  output logic       o_rvalid,
  input  wire        i_rready,
  output axi_resp_t  o_rresp,
  output axi_data_t  o_rdata,
  output logic       o_wr_stb,
  output reg_index_t o_wr_index,
  output axi_data_t  o_wr_data,
  input  wire        i_wr_err,
  output reg_index_t o_rd_index,
  input  axi_data_t  i_rd_data,
  input  wire        i_rd_err
);

  wr_state_e  r_wr_state;
  rd_state_e  r_rd_state;
  logic       r_rd_pend;
  reg_index_t r_rd_index;
  axi_resp_t  r_bresp;
  axi_resp_t  r_rresp;
  axi_data_t  r_rdata;
  logic       w_wr_accept;
  logic       w_rd_accept;

  // Write takes address and data in the same cycle
  assign w_wr_accept = (r_wr_state == WR_IDLE) && i_awvalid && i_wvalid;
  assign o_awready   = w_wr_accept;
  assign o_wready    = w_wr_accept;
  assign o_wr_stb    = w_wr_accept;
  assign o_wr_index  = i_awaddr[`IMX_ADDR_WIDTH-1:2];
  assign o_wr_data   = i_wdata;
  assign o_bvalid    = (r_wr_state == WR_RESP);
  assign o_bresp     = r_bresp;

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_wr_state <= WR_IDLE;
    end else begin
      case (r_wr_state)
        WR_IDLE: if (w_wr_accept) r_wr_state <= WR_RESP;
        WR_RESP: if (i_bready) r_wr_state <= WR_IDLE;
        default: r_wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_axi_clk) begin
    if (w_wr_accept) begin
      r_bresp <= i_wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Read index is registered, bank data is sampled one cycle later
  assign w_rd_accept = (r_rd_state == RD_IDLE) && !r_rd_pend && i_arvalid;
  assign o_arready   = w_rd_accept;
  assign o_rd_index  = r_rd_index;
  assign o_rvalid    = (r_rd_state == RD_DATA);
  assign o_rresp     = r_rresp;
  assign o_rdata     = r_rdata;

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_rd_state <= RD_IDLE;
      r_rd_pend  <= 1'b0;
    end else begin
      case (r_rd_state)
        RD_IDLE: begin
          if (r_rd_pend) begin
            r_rd_state <= RD_DATA;
            r_rd_pend  <= 1'b0;
          end else if (w_rd_accept) begin
            r_rd_pend <= 1'b1;
          end
        end
        RD_DATA: if (i_rready) r_rd_state <= RD_IDLE;
        default: r_rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_axi_clk) begin
    if (w_rd_accept) begin
      r_rd_index <= i_araddr[`IMX_ADDR_WIDTH-1:2];
    end
    if ((r_rd_state == RD_IDLE) && r_rd_pend) begin
      r_rdata <= i_rd_data;
      r_rresp <= i_rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Response must wait for the master
  a_bvalid_hold: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    o_bvalid && !i_bready |=> o_bvalid);

  // No new write while a response is outstanding
  a_no_aw_during_b: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    o_bvalid |-> !o_awready);

endmodule

`default_nettype wire

// File: rtl/imx_ctrl_pkg.sv
// Shared types for the IMX camera controller.
// Vector typedefs for bus, register and trigger widths, the AXI
// response codes and the state encodings of the bus slave.

`default_nettype none

`include "imx_ctrl_config.svh"

package imx_ctrl_pkg;

  typedef logic [`IMX_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [`IMX_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [1:0]                   axi_resp_t;
  typedef logic [`IMX_ADDR_WIDTH-3:0]   reg_index_t;
  typedef logic [31:0]                  trig_count_t;
  typedef logic [`IMX_TAP_WIDTH-1:0]    tap_value_t;
  typedef logic [`IMX_CAMERA_COUNT-1:0] cam_vec_t;
  typedef logic [`IMX_CAMERA_COUNT*`IMX_LANE_COUNT*`IMX_TAP_WIDTH-1:0] tap_bus_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Write channel, response held in WR_RESP
  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;

  // Read channel, data held in RD_DATA
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

endpackage

`default_nettype wire

// File: include/imx_ctrl_config.svh
// Build-time constants for the IMX camera controller.
// Holds bus widths, the register word map, control bit positions,
// reset defaults and the version word. Included by the package and
// by any RTL file that decodes registers or addresses.

`ifndef IMX_CTRL_CONFIG_SVH
`define IMX_CTRL_CONFIG_SVH

// Bus and sensor geometry
`define IMX_ADDR_WIDTH          9
`define IMX_DATA_WIDTH          32
`define IMX_CAMERA_COUNT        3
`define IMX_LANE_COUNT          8
`define IMX_MAX_LANE_COUNT      16
`define IMX_TAP_WIDTH           5

// Register map, in 32-bit word indices
`define IMX_REG_CONTROL         0
`define IMX_REG_PULSE_WIDTH     3
`define IMX_REG_PERIOD          4
`define IMX_REG_CAMERA_COUNT    5
`define IMX_REG_LANE_COUNT      6
`define IMX_REG_TAP_START       16
`define IMX_REG_VERSION         64

// Control word bits, master modes take one bit per camera from MASTER0 up
`define IMX_CTRL_BIT_CLEAR      0
`define IMX_CTRL_BIT_TAP_RST    1
`define IMX_CTRL_BIT_TRIG_EN    2
`define IMX_CTRL_BIT_CLK_RST    4
`define IMX_CTRL_BIT_CAM_RST    5
`define IMX_CTRL_BIT_MASTER0    12

// Trigger defaults, about 200 Hz at 74 MHz
`define IMX_DEFAULT_PULSE_WIDTH 100
`define IMX_DEFAULT_PERIOD      370000

`define IMX_VERSION_MAJOR       4'd1
`define IMX_VERSION_MINOR       8'd0
`define IMX_VERSION_REVISION    4'd0
`define IMX_VERSION_WORD        {`IMX_VERSION_MAJOR, `IMX_VERSION_MINOR, \
                                 `IMX_VERSION_REVISION, 16'h0000}

`endif
